/* tb/dm_trace.txt */
# name op addr data halted unavail resumeack cmdbusy hold expected, all hex but name
# op 3 probes: addr 0 haltreq_o, 1 cmd_o, 2 cmd_valid_o, 3 clear_resumeack_o, 4 req ready
act_on           2 10 00000001 0 0 0 0 0 00000000
status_h0        1 11 00000000 0 0 0 0 0 000c0c82
sel_h5           2 10 00050001 0 0 0 0 0 00000000
status_h5        1 11 00000000 0 0 0 0 0 0000c082
ack_h0           2 10 10000001 0 0 0 0 0 00000000
status_ack       1 11 00000000 0 0 0 0 0 00000c82
halt_h2          2 10 80020001 0 0 0 0 0 00000000
chk_haltreq      3 00 00000000 0 0 0 0 0 00000004
resume_h2        2 10 40020001 0 0 0 0 0 00000000
chk_clrack       3 03 00000000 0 0 0 0 0 00000001
resume_held      1 10 00000000 0 0 0 0 0 40020001
ack_wait         3 00 00000000 0 0 4 0 0 00000000
resume_cleared   1 10 00000000 0 0 0 0 0 00020001
cmd_write        2 17 00ab1234 0 0 0 0 0 00000000
chk_cmdvalid     3 02 00000000 0 0 0 0 0 00000001
chk_cmd          3 01 00000000 0 0 0 0 0 00ab1234
cmd_busy         2 17 11112222 0 0 0 1 0 00000000
chk_no_cmdvalid  3 02 00000000 0 0 0 0 0 00000000
chk_cmd_kept     3 01 00000000 0 0 0 0 0 00ab1234
cs_busy_err      1 16 00000000 0 0 0 0 0 00000102
cs_clear         2 16 00000700 0 0 0 0 0 00000000
cs_cleared       1 16 00000000 0 0 0 0 0 00000002
d0_write         2 04 cafef00d 0 0 0 0 0 00000000
d1_write         2 05 12345678 0 0 0 0 0 00000000
d0_read          1 04 00000000 0 0 0 0 0 cafef00d
auto_set         2 18 00000002 0 0 0 0 0 00000000
d1_auto_read     1 05 00000000 0 0 0 0 0 12345678
chk_autoexec     3 02 00000000 0 0 0 0 0 00000001
bp_req0          1 04 00000000 0 0 0 0 1 cafef00d
bp_req1          1 05 00000000 0 0 0 0 1 12345678
chk_ready_low    3 04 00000000 0 0 0 0 1 00000000
bp_req2          1 16 00000000 0 0 0 0 0 00000002
busy_err_again   2 17 00000000 0 0 0 1 0 00000000
cs_err_set       1 16 00000000 0 0 0 0 0 00000102
halt_h2b         2 10 80020001 0 0 0 0 0 00000000
chk_halt_on      3 00 00000000 0 0 0 0 0 00000004
deact            2 10 00000000 0 0 0 0 0 00000000
chk_halt_off     3 00 00000000 0 0 0 0 0 00000000
cmd_off          1 17 00000000 0 0 0 0 0 00000000
d0_off           1 04 00000000 0 0 0 0 0 00000000
d1_off           1 05 00000000 0 0 0 0 0 00000000
cs_off           1 16 00000000 0 0 0 0 0 00000002

/* sources.f */
logic/dm_pkg.sv
logic/dm_resp_fifo.sv
logic/dm_hart_ctrl.sv
logic/dm_abstract_cmd.sv
logic/dm_regs_top.sv
tb/tb_clock_gen.sv
tb/tb_dm_regs.sv

/* tb/tb_dm_regs.sv */
`timescale 1ns/100ps

module tb_dm_regs;

  localparam int MaxSteps = 64;
  localparam int ProbeOp  = 3;

  logic                                     clk;
  logic                                     rst_n;
  logic                                     req_valid;
  logic                                     req_ready;
  dm_pkg::dmi_req_t                         req;
  logic                                     resp_valid;
  logic                                     resp_ready;
  dm_pkg::dmi_resp_t                        resp;
  dm_pkg::hart_vec_t                        halted;
  dm_pkg::hart_vec_t                        unavail;
  dm_pkg::hart_vec_t                        rack;
  dm_pkg::hart_vec_t                        haltreq;
  dm_pkg::hart_vec_t                        resumereq;
  logic                                     clear_resumeack;
  logic                                     ndmreset;
  logic                                     dmactive;
  logic                                     cmdbusy;
  logic                                     cmderror_valid;
  dm_pkg::cmderr_e                          cmderror;
  logic                                     data_valid;
  dm_pkg::dm_word_t [dm_pkg::DataCount-1:0] data_in;
  logic                                     cmd_valid;
  dm_pkg::command_t                         cmd;
  dm_pkg::dm_word_t [dm_pkg::DataCount-1:0] data_out;

  // trace steps
  string             step_name   [MaxSteps];
  int                step_op     [MaxSteps];
  dm_pkg::dm_addr_t  step_addr   [MaxSteps];
  dm_pkg::dm_word_t  step_data   [MaxSteps];
  dm_pkg::hart_vec_t step_halted [MaxSteps];
  dm_pkg::hart_vec_t step_unavail[MaxSteps];
  dm_pkg::hart_vec_t step_rack   [MaxSteps];
  logic              step_busy   [MaxSteps];
  logic              step_hold   [MaxSteps];
  dm_pkg::dm_word_t  step_exp    [MaxSteps];
  int                step_count;

  // expected responses in issue order
  dm_pkg::dm_word_t  exp_q[$];
  string             exp_name_q[$];
  dm_pkg::dmi_resp_t exp_resp;

  int value_errors;
  int other_errors;
  int cmd_valid_cnt;
  int clrack_cnt;
  int cycles;
  int cycle_limit;

  tb_clock_gen i_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  dm_regs_top i_dut (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .dmi_req_valid_i   (req_valid),
    .dmi_req_ready_o   (req_ready),
    .dmi_req_i         (req),
    .dmi_resp_valid_o  (resp_valid),
    .dmi_resp_ready_i  (resp_ready),
    .dmi_resp_o        (resp),
    .halted_i          (halted),
    .unavailable_i     (unavail),
    .resumeack_i       (rack),
    .haltreq_o         (haltreq),
    .resumereq_o       (resumereq),
    .clear_resumeack_o (clear_resumeack),
    .ndmreset_o        (ndmreset),
    .dmactive_o        (dmactive),
    .cmdbusy_i         (cmdbusy),
    .cmderror_valid_i  (cmderror_valid),
    .cmderror_i        (cmderror),
    .data_valid_i      (data_valid),
    .data_i            (data_in),
    .cmd_valid_o       (cmd_valid),
    .cmd_o             (cmd),
    .data_o            (data_out)
  );

  // ----------------------------------------------------------------------
  // compare tasks
  // ----------------------------------------------------------------------
  task automatic check_word(input string name, input dm_pkg::dm_word_t exp,
                            input dm_pkg::dm_word_t act);
    if (act !== exp) begin
      value_errors++;
      $display("** Error %s: expected %08h, actual %08h", name, exp, act);
    end
  endtask

  task automatic check_harts(input string name, input dm_pkg::hart_vec_t exp,
                             input dm_pkg::hart_vec_t act);
    if (act !== exp) begin
      value_errors++;
      $display("** Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errors++;
      $display("** Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_resp(input string name, input dm_pkg::dmi_resp_t exp,
                            input dm_pkg::dmi_resp_t act);
    if (act !== exp) begin
      value_errors++;
      $display("** Error %s: expected %09h, actual %09h", name, exp, act);
    end
  endtask

  // a pulse must show up at most once between probes
  task automatic check_pulse(input string name, input logic exp, input int count);
    check_bit(name, exp, count != 0);
    if (count > 1) begin
      other_errors++;
      $display("%s: the pulse was seen %0d times instead of once", name, count);
    end
  endtask

  // one request bit placed at the hart that a dmcontrol word selects
  function automatic dm_pkg::hart_vec_t steer_to_hart(input dm_pkg::dm_word_t ctrl,
                                                      input logic req_bit);
    dm_pkg::hart_vec_t harts;
    harts = '0;
    if (ctrl[25:16] < dm_pkg::NrHarts) begin
      harts[ctrl[25:16]] = req_bit;
    end
    return harts;
  endfunction

  // hart side outputs follow the register that a read returns
  task automatic check_read_side(input int idx);
    case (step_addr[idx])
      dm_pkg::Data0: check_word({step_name[idx], "_data_o"}, step_exp[idx], data_out[0]);
      dm_pkg::Data1: check_word({step_name[idx], "_data_o"}, step_exp[idx], data_out[1]);
      dm_pkg::DMControl: begin
        check_harts({step_name[idx], "_haltreq_o"},
                    steer_to_hart(step_exp[idx], step_exp[idx][31]), haltreq);
        check_harts({step_name[idx], "_resumereq_o"},
                    steer_to_hart(step_exp[idx], step_exp[idx][30]), resumereq);
      end
      default: ;
    endcase
  endtask

  // ----------------------------------------------------------------------
  // trace loading and replay
  // ----------------------------------------------------------------------
  task automatic load_trace();
    int          fd;
    int          n;
    string       line;
    string       name;
    int          op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] hlt;
    logic [31:0] unav;
    logic [31:0] ack;
    logic [31:0] busy;
    logic [31:0] hold;
    logic [31:0] exp;
    fd = $fopen("tb/dm_trace.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("could not open the trace file tb/dm_trace.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", name, op, addr, data,
                      hlt, unav, ack, busy, hold, exp);
          if (n == 10 && step_count < MaxSteps) begin
            step_name[step_count]    = name;
            step_op[step_count]      = op;
            step_addr[step_count]    = addr[6:0];
            step_data[step_count]    = data;
            step_halted[step_count]  = hlt[dm_pkg::NrHarts-1:0];
            step_unavail[step_count] = unav[dm_pkg::NrHarts-1:0];
            step_rack[step_count]    = ack[dm_pkg::NrHarts-1:0];
            step_busy[step_count]    = busy[0];
            step_hold[step_count]    = hold[0];
            step_exp[step_count]     = exp;
            step_count++;
          end else if (n == 10) begin
            other_errors++;
            $display("the trace holds more than %0d steps", MaxSteps);
          end else if (n > 0) begin
            other_errors++;
            $display("malformed trace line: %s", line);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic issue_request(input int idx);
    req_valid = 1'b1;
    req.addr  = step_addr[idx];
    req.op    = dm_pkg::dtm_op_e'(step_op[idx][1:0]);
    req.data  = step_data[idx];
    exp_q.push_back(step_exp[idx]);
    exp_name_q.push_back(step_name[idx]);
    @(negedge clk);
    if (step_op[idx] == dm_pkg::DtmRead) begin
      check_read_side(idx);
    end
    while (!req_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  // addr picks the output and every probe restarts the pulse counts
  task automatic probe_output(input int idx);
    req_valid = 1'b0;
    @(negedge clk);
    @(posedge clk);
    #1;
    case (step_addr[idx])
      7'd0: check_harts(step_name[idx], step_exp[idx][dm_pkg::NrHarts-1:0], haltreq);
      7'd1: check_word(step_name[idx], step_exp[idx], dm_pkg::dm_word_t'(cmd));
      7'd2: check_pulse(step_name[idx], step_exp[idx][0], cmd_valid_cnt);
      7'd3: check_pulse(step_name[idx], step_exp[idx][0], clrack_cnt);
      7'd4: check_bit(step_name[idx], step_exp[idx][0], req_ready);
      default: begin
        other_errors++;
        $display("%s: unknown probe selector %0h", step_name[idx], step_addr[idx]);
      end
    endcase
    cmd_valid_cnt = 0;
    clrack_cnt    = 0;
  endtask

  task automatic run_step(input int idx);
    halted     = step_halted[idx];
    unavail    = step_unavail[idx];
    rack       = step_rack[idx];
    cmdbusy    = step_busy[idx];
    resp_ready = !step_hold[idx];
    if (step_op[idx] == ProbeOp) begin
      probe_output(idx);
    end else begin
      issue_request(idx);
    end
  endtask

  // ----------------------------------------------------------------------
  // monitors
  // ----------------------------------------------------------------------
  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (rst_n === 1'b1) begin
      if (cmd_valid) begin
        cmd_valid_cnt++;
      end
      if (clear_resumeack) begin
        clrack_cnt++;
      end
      if (resp_valid && resp_ready) begin
        if (exp_q.size() == 0) begin
          other_errors++;
          $display("a response arrived with no request outstanding");
        end else begin
          exp_resp.data = exp_q.pop_front();
          exp_resp.resp = dm_pkg::DtmSuccess;
          check_resp(exp_name_q.pop_front(), exp_resp, resp);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the trace did not complete", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    req_valid      = 1'b0;
    req            = '0;
    resp_ready     = 1'b1;
    halted         = '0;
    unavail        = '0;
    rack           = '0;
    cmdbusy        = 1'b0;
    cmderror_valid = 1'b0;
    cmderror       = dm_pkg::CmdErrNone;
    data_valid     = 1'b0;
    data_in        = '0;
    value_errors   = 0;
    other_errors   = 0;
    cmd_valid_cnt  = 0;
    clrack_cnt     = 0;
    step_count     = 0;
    cycle_limit    = 0;
    load_trace();
    if (step_count == 0) begin
      other_errors++;
      $display("the trace holds no steps");
    end
    cycle_limit = 20 * step_count + 50;
    wait (rst_n === 1'b1);
    @(posedge clk);
    #1;
    check_bit("reset_resp_valid", 1'b0, resp_valid);
    check_bit("reset_cmd_valid", 1'b0, cmd_valid);
    check_harts("reset_haltreq", '0, haltreq);
    check_bit("reset_ndmreset", 1'b0, ndmreset);
    check_bit("reset_dmactive", 1'b0, dmactive);
    for (int i = 0; i < step_count; i++) begin
      run_step(i);
    end
    // drain what is still queued
    req_valid  = 1'b0;
    resp_ready = 1'b1;
    cmdbusy    = 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    @(posedge clk);
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // reset held low for four rising edges
  initial begin
    rst_no = 1'b0;
    repeat (4) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

/* logic/dm_regs_top.sv */
`timescale 1ns/100ps

module dm_regs_top (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  // transport side
  input  logic                                      dmi_req_valid_i,
  output logic                                      dmi_req_ready_o,
  input  dm_pkg::dmi_req_t                          dmi_req_i,
  output logic                                      dmi_resp_valid_o,
  input  logic                                      dmi_resp_ready_i,
  output dm_pkg::dmi_resp_t                         dmi_resp_o,
  // hart run control
  input  dm_pkg::hart_vec_t                         halted_i,
  input  dm_pkg::hart_vec_t                         unavailable_i,
  input  dm_pkg::hart_vec_t                         resumeack_i,
  output dm_pkg::hart_vec_t                         haltreq_o,
  output dm_pkg::hart_vec_t                         resumereq_o,
  output logic                                      clear_resumeack_o,
  output logic                                      ndmreset_o,
  output logic                                      dmactive_o,
  // abstract commands
  input  logic                                      cmdbusy_i,
  input  logic                                      cmderror_valid_i,
  input  dm_pkg::cmderr_e                           cmderror_i,
  input  logic                                      data_valid_i,
  input  dm_pkg::dm_word_t [dm_pkg::DataCount-1:0]  data_i,
  output logic                                      cmd_valid_o,
  output dm_pkg::command_t                          cmd_o,
  output dm_pkg::dm_word_t [dm_pkg::DataCount-1:0]  data_o
);

  logic             req_fire;
  dm_pkg::dm_word_t hart_rdata;
  dm_pkg::dm_word_t abs_rdata;
  dm_pkg::dm_word_t resp_wdata;
  dm_pkg::dm_word_t resp_rdata;

  assign req_fire = dmi_req_valid_i & dmi_req_ready_o;

  // writes and unknown addresses answer zero
  assign resp_wdata = (dmi_req_i.op == dm_pkg::DtmRead) ? (hart_rdata | abs_rdata) : '0;

  assign dmi_resp_o = '{data: resp_rdata, resp: dm_pkg::DtmSuccess};

  dm_hart_ctrl i_hart_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .req_fire_i        (req_fire),
    .dmi_req_i         (dmi_req_i),
    .halted_i          (halted_i),
    .unavailable_i     (unavailable_i),
    .resumeack_i       (resumeack_i),
    .rdata_o           (hart_rdata),
    .haltreq_o         (haltreq_o),
    .resumereq_o       (resumereq_o),
    .clear_resumeack_o (clear_resumeack_o),
    .ndmreset_o        (ndmreset_o),
    .dmactive_o        (dmactive_o)
  );

  dm_abstract_cmd i_abstract_cmd (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_fire_i       (req_fire),
    .dmi_req_i        (dmi_req_i),
    .dmactive_i       (dmactive_o),
    .cmdbusy_i        (cmdbusy_i),
    .cmderror_valid_i (cmderror_valid_i),
    .cmderror_i       (cmderror_i),
    .data_valid_i     (data_valid_i),
    .data_i           (data_i),
    .rdata_o          (abs_rdata),
    .cmd_valid_o      (cmd_valid_o),
    .cmd_o            (cmd_o),
    .data_o           (data_o)
  );

  // queue full holds off the transport
  dm_resp_fifo i_resp_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wdata_i  (resp_wdata),
    .wvalid_i (req_fire),
    .wready_o (dmi_req_ready_o),
    .rdata_o  (resp_rdata),
    .rvalid_o (dmi_resp_valid_o),
    .rready_i (dmi_resp_ready_i)
  );

endmodule

/* logic/dm_abstract_cmd.sv */
`timescale 1ns/100ps

module dm_abstract_cmd (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      req_fire_i,
  input  dm_pkg::dmi_req_t                          dmi_req_i,
  input  logic                                      dmactive_i,
  input  logic                                      cmdbusy_i,
  input  logic                                      cmderror_valid_i,
  input  dm_pkg::cmderr_e                           cmderror_i,
  input  logic                                      data_valid_i,
  input  dm_pkg::dm_word_t [dm_pkg::DataCount-1:0]  data_i,
  output dm_pkg::dm_word_t                          rdata_o,
  output logic                                      cmd_valid_o,
  output dm_pkg::command_t                          cmd_o,
  output dm_pkg::dm_word_t [dm_pkg::DataCount-1:0]  data_o
);

  dm_pkg::command_t                         command_d, command_q;
  dm_pkg::cmderr_e                          cmderr_d, cmderr_q;
  logic [dm_pkg::DataCount-1:0]             autoexec_d, autoexec_q;
  dm_pkg::dm_word_t [dm_pkg::DataCount-1:0] data_d, data_q;
  logic                                     cmd_valid_d, cmd_valid_q;
  dm_pkg::abstractcs_t                      abstractcs;
  dm_pkg::abstractcs_t                      wr_cs;
  dm_pkg::dm_addr_t                         data_offset;
  logic [$clog2(dm_pkg::DataCount)-1:0]     data_idx;
  logic                                     data_hit;
  logic                                     is_read;
  logic                                     is_write;

  assign is_read  = req_fire_i && (dmi_req_i.op == dm_pkg::DtmRead);
  assign is_write = req_fire_i && (dmi_req_i.op == dm_pkg::DtmWrite);
  assign wr_cs    = dm_pkg::abstractcs_t'(dmi_req_i.data);

  // data window starts at Data0
  assign data_offset = dmi_req_i.addr - dm_pkg::Data0;
  assign data_hit    = (data_offset < 7'(dm_pkg::DataCount));
  assign data_idx    = data_offset[$clog2(dm_pkg::DataCount)-1:0];

  // ----------------------------------------------------------------------
  // next state
  // ----------------------------------------------------------------------
  always_comb begin
    command_d   = command_q;
    cmderr_d    = cmderr_q;
    autoexec_d  = autoexec_q;
    data_d      = data_q;
    cmd_valid_d = 1'b0;
    // data access, ignored while busy
    if ((is_read || is_write) && data_hit && !cmdbusy_i) begin
      if (is_write) begin
        data_d[data_idx] = dmi_req_i.data;
      end
      cmd_valid_d = autoexec_q[data_idx];
    end
    if (is_write) begin
      case (dmi_req_i.addr)
        dm_pkg::Command: begin
          if (!cmdbusy_i) begin
            command_d   = dm_pkg::command_t'(dmi_req_i.data);
            cmd_valid_d = 1'b1;
          end else if (cmderr_q == dm_pkg::CmdErrNone) begin
            cmderr_d = dm_pkg::CmdErrBusy;
          end
        end
        dm_pkg::AbstractCS: begin
          // w1c on cmderr
          if (!cmdbusy_i) begin
            cmderr_d = dm_pkg::cmderr_e'(cmderr_q & ~wr_cs.cmderr);
          end else if (cmderr_q == dm_pkg::CmdErrNone) begin
            cmderr_d = dm_pkg::CmdErrBusy;
          end
        end
        dm_pkg::AbstractAuto: begin
          if (!cmdbusy_i) begin
            autoexec_d = dmi_req_i.data[dm_pkg::DataCount-1:0];
          end else if (cmderr_q == dm_pkg::CmdErrNone) begin
            cmderr_d = dm_pkg::CmdErrBusy;
          end
        end
        default: ;
      endcase
    end
    // hart side wins over the bus
    if (cmderror_valid_i) begin
      cmderr_d = cmderror_i;
    end
    if (data_valid_i) begin
      data_d = data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      command_q   <= '0;
      cmderr_q    <= dm_pkg::CmdErrNone;
      autoexec_q  <= '0;
      data_q      <= '0;
      cmd_valid_q <= 1'b0;
    end else if (!dmactive_i) begin
      command_q   <= '0;
      cmderr_q    <= dm_pkg::CmdErrNone;
      autoexec_q  <= '0;
      data_q      <= '0;
      cmd_valid_q <= 1'b0;
    end else begin
      command_q   <= command_d;
      cmderr_q    <= cmderr_d;
      autoexec_q  <= autoexec_d;
      data_q      <= data_d;
      cmd_valid_q <= cmd_valid_d;
    end
  end

  // ----------------------------------------------------------------------
  // read values
  // ----------------------------------------------------------------------
  always_comb begin
    abstractcs             = '0;
    abstractcs.datacount   = 4'(dm_pkg::DataCount);
    abstractcs.cmderr      = cmderr_q;
    abstractcs.busy        = cmdbusy_i;
    abstractcs.progbufsize = '0;
  end

  always_comb begin
    rdata_o = '0;
    if (data_hit) begin
      rdata_o = data_q[data_idx];
    end else begin
      case (dmi_req_i.addr)
        dm_pkg::AbstractCS:   rdata_o = abstractcs;
        dm_pkg::Command:      rdata_o = command_q;
        dm_pkg::AbstractAuto: rdata_o[dm_pkg::DataCount-1:0] = autoexec_q;
        default:              rdata_o = '0;
      endcase
    end
  end

  assign cmd_valid_o = cmd_valid_q;
  assign cmd_o       = command_q;
  assign data_o      = data_q;

endmodule

/* logic/dm_hart_ctrl.sv */
`timescale 1ns/100ps

module dm_hart_ctrl (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_fire_i,
  input  dm_pkg::dmi_req_t   dmi_req_i,
  input  dm_pkg::hart_vec_t  halted_i,
  input  dm_pkg::hart_vec_t  unavailable_i,
  input  dm_pkg::hart_vec_t  resumeack_i,
  output dm_pkg::dm_word_t   rdata_o,
  output dm_pkg::hart_vec_t  haltreq_o,
  output dm_pkg::hart_vec_t  resumereq_o,
  output logic               clear_resumeack_o,
  output logic               ndmreset_o,
  output logic               dmactive_o
);

  dm_pkg::dmcontrol_t dmcontrol_d, dmcontrol_q;
  dm_pkg::dmcontrol_t wr_ctrl;
  dm_pkg::hart_vec_t  havereset_d, havereset_q;
  dm_pkg::dmstatus_t  dmstatus;
  dm_pkg::hart_idx_t  sel_hart;
  dm_pkg::hart_idx_t  wr_hart;
  logic               sel_exists;
  logic               wr_exists;
  logic               ctrl_write;
  logic               sel_halted;
  logic               sel_unavail;
  logic               next_active;

  assign wr_ctrl    = dm_pkg::dmcontrol_t'(dmi_req_i.data);
  assign ctrl_write = req_fire_i && (dmi_req_i.op == dm_pkg::DtmWrite) &&
                      (dmi_req_i.addr == dm_pkg::DMControl);

  // harts beyond NrHarts do not exist
  assign sel_hart   = dm_pkg::hart_idx_t'(dmcontrol_q.hartsello);
  assign sel_exists = (dmcontrol_q.hartsello < 10'(dm_pkg::NrHarts));
  assign wr_hart    = dm_pkg::hart_idx_t'(wr_ctrl.hartsello);
  assign wr_exists  = (wr_ctrl.hartsello < 10'(dm_pkg::NrHarts));

  // ----------------------------------------------------------------------
  // dmcontrol and havereset next state
  // ----------------------------------------------------------------------
  always_comb begin
    dmcontrol_d = dmcontrol_q;
    havereset_d = havereset_q;
    if (ctrl_write) begin
      dmcontrol_d = wr_ctrl;
      // ack applies to the hart named in this write
      if (wr_ctrl.ackhavereset && wr_exists) begin
        havereset_d[wr_hart] = 1'b0;
      end
    end
    if (dmcontrol_q.resumereq && sel_exists && resumeack_i[sel_hart]) begin
      dmcontrol_d.resumereq = 1'b0;
    end
    dmcontrol_d.ackhavereset = 1'b0;
    dmcontrol_d.zero2        = 1'b0;
    dmcontrol_d.zero1        = '0;
    dmcontrol_d.zero0        = '0;
    // inactive module keeps only dmactive
    next_active = dmcontrol_d.dmactive;
    if (!(dmcontrol_q.dmactive && next_active)) begin
      dmcontrol_d          = '0;
      dmcontrol_d.dmactive = next_active;
    end
    if (dmcontrol_q.ndmreset) begin
      havereset_d = '1;
    end
  end

  assign clear_resumeack_o = !dmcontrol_q.resumereq && dmcontrol_d.resumereq;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dmcontrol_q <= '0;
      havereset_q <= '1;
    end else begin
      dmcontrol_q <= dmcontrol_d;
      havereset_q <= havereset_d;
    end
  end

  // ----------------------------------------------------------------------
  // status of the selected hart
  // ----------------------------------------------------------------------
  assign sel_halted  = sel_exists & halted_i[sel_hart];
  assign sel_unavail = sel_exists & unavailable_i[sel_hart];

  always_comb begin
    dmstatus                = '0;
    dmstatus.version        = dm_pkg::DbgVersion013;
    dmstatus.authenticated  = 1'b1;
    dmstatus.anyhalted      = sel_halted & ~sel_unavail;
    dmstatus.allhalted      = sel_halted & ~sel_unavail;
    dmstatus.anyrunning     = sel_exists & ~sel_halted & ~sel_unavail;
    dmstatus.allrunning     = sel_exists & ~sel_halted & ~sel_unavail;
    dmstatus.anyunavail     = sel_unavail;
    dmstatus.allunavail     = sel_unavail;
    dmstatus.anynonexistent = ~sel_exists;
    dmstatus.allnonexistent = ~sel_exists;
    dmstatus.anyresumeack   = sel_exists & resumeack_i[sel_hart];
    dmstatus.allresumeack   = sel_exists & resumeack_i[sel_hart];
    dmstatus.anyhavereset   = sel_exists & havereset_q[sel_hart];
    dmstatus.allhavereset   = sel_exists & havereset_q[sel_hart];
  end

  // address decode only, the top masks non-read ops
  always_comb begin
    case (dmi_req_i.addr)
      dm_pkg::DMControl: rdata_o = dmcontrol_q;
      dm_pkg::DMStatus:  rdata_o = dmstatus;
      default:           rdata_o = '0;
    endcase
  end

  // requests go to the selected hart only
  always_comb begin
    haltreq_o   = '0;
    resumereq_o = '0;
    if (sel_exists) begin
      haltreq_o[sel_hart]   = dmcontrol_q.haltreq;
      resumereq_o[sel_hart] = dmcontrol_q.resumereq;
    end
  end

  assign ndmreset_o = dmcontrol_q.ndmreset;
  assign dmactive_o = dmcontrol_q.dmactive;

endmodule

/* logic/dm_resp_fifo.sv */
`timescale 1ns/100ps

module dm_resp_fifo (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  dm_pkg::dm_word_t wdata_i,
  input  logic             wvalid_i,
  output logic             wready_o,
  output dm_pkg::dm_word_t rdata_o,
  output logic             rvalid_o,
  input  logic             rready_i
);

  dm_pkg::dm_word_t mem_q [dm_pkg::RespDepth];
  logic             wptr_q;
  logic             rptr_q;
  logic [1:0]       count_q;
  logic             push;
  logic             pop;

  assign wready_o = (count_q != 2'(dm_pkg::RespDepth));
  assign rvalid_o = (count_q != 2'd0);
  assign rdata_o  = mem_q[rptr_q];

  assign push = wvalid_i & wready_o;
  assign pop  = rvalid_o & rready_i;

  // storage, written only on push
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

  // pointers wrap on their own with depth 2
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= 1'b0;
      rptr_q  <= 1'b0;
      count_q <= 2'd0;
    end else begin
      if (push) begin
        wptr_q <= ~wptr_q;
      end
      if (pop) begin
        rptr_q <= ~rptr_q;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

/* logic/dm_pkg.sv */
package dm_pkg;

  // ----------------------------------------------------------------------
  // sizes
  // ----------------------------------------------------------------------
  localparam int unsigned NrHarts    = 4;
  localparam int unsigned DataCount  = 2;
  localparam int unsigned HartSelLen = 2;
  localparam int unsigned RespDepth  = 2;

  // fixed field values
  localparam logic [3:0] DbgVersion013 = 4'd2;
  localparam logic [1:0] DtmSuccess    = 2'd0;

  typedef logic [31:0]           dm_word_t;
  typedef logic [6:0]            dm_addr_t;
  typedef logic [NrHarts-1:0]    hart_vec_t;
  typedef logic [HartSelLen-1:0] hart_idx_t;

  // ----------------------------------------------------------------------
  // encodings
  // ----------------------------------------------------------------------
  typedef enum logic [1:0] {
    DtmNop   = 2'd0,
    DtmRead  = 2'd1,
    DtmWrite = 2'd2
  } dtm_op_e;

  typedef enum logic [6:0] {
    Data0        = 7'h04,
    Data1        = 7'h05,
    DMControl    = 7'h10,
    DMStatus     = 7'h11,
    AbstractCS   = 7'h16,
    Command      = 7'h17,
    AbstractAuto = 7'h18
  } dm_csr_e;

  typedef enum logic [2:0] {
    CmdErrNone         = 3'd0,
    CmdErrBusy         = 3'd1,
    CmdErrNotSupported = 3'd2,
    CmdErrException    = 3'd3,
    CmdErrHaltResume   = 3'd4,
    CmdErrBus          = 3'd5,
    CmdErrOther        = 3'd7
  } cmderr_e;

  // ----------------------------------------------------------------------
  // transport and register layouts
  // ----------------------------------------------------------------------
  typedef struct packed {
    dm_addr_t addr;
    dtm_op_e  op;
    dm_word_t data;
  } dmi_req_t;

  typedef struct packed {
    dm_word_t   data;
    logic [1:0] resp;
  } dmi_resp_t;

  typedef struct packed {
    logic        haltreq;
    logic        resumereq;
    logic        zero2;
    logic        ackhavereset;
    logic [1:0]  zero1;
    logic [9:0]  hartsello;
    logic [13:0] zero0;
    logic        ndmreset;
    logic        dmactive;
  } dmcontrol_t;

  typedef struct packed {
    logic [11:0] zero1;
    logic        allhavereset;
    logic        anyhavereset;
    logic        allresumeack;
    logic        anyresumeack;
    logic        allnonexistent;
    logic        anynonexistent;
    logic        allunavail;
    logic        anyunavail;
    logic        allrunning;
    logic        anyrunning;
    logic        allhalted;
    logic        anyhalted;
    logic        authenticated;
    logic [2:0]  zero0;
    logic [3:0]  version;
  } dmstatus_t;

  typedef struct packed {
    logic [2:0]  zero3;
    logic [4:0]  progbufsize;
    logic [10:0] zero2;
    logic        busy;
    logic        zero1;
    cmderr_e     cmderr;
    logic [3:0]  zero0;
    logic [3:0]  datacount;
  } abstractcs_t;

  typedef struct packed {
    logic [7:0]  cmdtype;
    logic [23:0] control;
  } command_t;

endpackage
